//--- design/spi_pkg.sv
// Shared register map, field positions, widths and state enums for the SPI master; scoped by name
`default_nettype none

package spi_pkg;

    localparam int SPI_DATA_WIDTH    = 8;
    localparam int SPI_DIVIDER_WIDTH = 16;
    localparam int SPI_WAIT_WIDTH    = 16;
    localparam int SPI_SELECT_WIDTH  = 8;   // Slave index field of REG_SLAVE
    localparam int AXIL_ADDR_WIDTH   = 5;
    localparam int AXIL_DATA_WIDTH   = 32;
    localparam int SPI_REG_NUM       = 8;

    typedef logic [SPI_DATA_WIDTH-1:0] spi_data_t;

    // Byte address is four times the index
    typedef enum logic [2:0] {
        REG_PARAM       = 3'd0,
        REG_CONTROL     = 3'd1,
        REG_STATUS      = 3'd2,
        REG_SLAVE       = 3'd3,
        REG_CLK_DIVIDER = 3'd4,
        REG_WAIT_TIME   = 3'd5,
        REG_TX          = 3'd6,
        REG_RX          = 3'd7
    } spi_reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        SHIFT,
        PUSH
    } spi_state_e;

    // Registers that hold host writes, one bit per index
    localparam logic [SPI_REG_NUM-1:0] SPI_REG_WRITABLE = 8'b0111_1010;

    localparam int SPI_CTRL_RESET_POS = 0;
    localparam int SPI_CTRL_CPOL_POS  = 1;
    localparam int SPI_CTRL_CPHA_POS  = 2;

    localparam int SPI_LAST_POS = 8;  // Last flag above the data byte in TX and RX

    localparam int SPI_STATUS_RX_EMPTY_POS = 0;
    localparam int SPI_STATUS_TX_EMPTY_POS = 1;
    localparam int SPI_STATUS_RX_FULL_POS  = 2;
    localparam int SPI_STATUS_TX_FULL_POS  = 3;

    localparam logic [SPI_DIVIDER_WIDTH-1:0] SPI_DIVIDER_INIT = 1;
    localparam logic [SPI_WAIT_WIDTH-1:0]    SPI_WAIT_INIT    = 0;

endpackage

`default_nettype wire

//--- design/spi_reg_file.sv
// AXI-Lite slave register file; holds host settings and emits per-register access strobes
`timescale 1ns/1ns
`default_nettype none

module spi_reg_file (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic [spi_pkg::AXIL_ADDR_WIDTH-1:0]   s_awaddr_i,
    input  logic                                  s_awvalid_i,
    output logic                                  s_awready_o,
    input  logic [spi_pkg::AXIL_DATA_WIDTH-1:0]   s_wdata_i,
    input  logic                                  s_wvalid_i,
    output logic                                  s_wready_o,
    output logic                                  s_bvalid_o,
    input  logic                                  s_bready_i,
    input  logic [spi_pkg::AXIL_ADDR_WIDTH-1:0]   s_araddr_i,
    input  logic                                  s_arvalid_i,
    output logic                                  s_arready_o,
    output logic [spi_pkg::AXIL_DATA_WIDTH-1:0]   s_rdata_o,
    output logic                                  s_rvalid_o,
    input  logic                                  s_rready_i,
    input  logic [spi_pkg::SPI_REG_NUM-1:0][spi_pkg::AXIL_DATA_WIDTH-1:0] rd_data_i,
    output logic [spi_pkg::SPI_REG_NUM-1:0][spi_pkg::AXIL_DATA_WIDTH-1:0] wr_data_o,
    output logic [spi_pkg::SPI_REG_NUM-1:0]       wr_valid_o,
    output logic [spi_pkg::SPI_REG_NUM-1:0]       rd_request_o
);

    logic [spi_pkg::SPI_REG_NUM-1:0][spi_pkg::AXIL_DATA_WIDTH-1:0] regs;
    spi_pkg::spi_reg_addr_e waddr;
    spi_pkg::spi_reg_addr_e raddr;
    logic                   wr_hs;
    logic                   rd_hs;
    logic                   bvalid_q;
    logic                   rvalid_q;

    // Word index from the byte address
    assign waddr = spi_pkg::spi_reg_addr_e'(s_awaddr_i[spi_pkg::AXIL_ADDR_WIDTH-1:2]);
    assign raddr = spi_pkg::spi_reg_addr_e'(s_araddr_i[spi_pkg::AXIL_ADDR_WIDTH-1:2]);

    // Address and data are taken together, one write outstanding
    assign wr_hs       = s_awvalid_i & s_wvalid_i & ~bvalid_q;
    assign s_awready_o = wr_hs;
    assign s_wready_o  = wr_hs;
    assign s_bvalid_o  = bvalid_q;

    assign rd_hs       = s_arvalid_i & ~rvalid_q;
    assign s_arready_o = rd_hs;
    assign s_rvalid_o  = rvalid_q;

    always_comb begin
        for (int i = 0; i < spi_pkg::SPI_REG_NUM; i++) begin
            wr_valid_o[i]   = wr_hs && (waddr == i);
            rd_request_o[i] = rd_hs && (raddr == i);
            // Incoming word is forwarded so a strobe sees its own data
            wr_data_o[i]    = wr_valid_o[i] ? s_wdata_i : regs[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            regs <= '0;
            regs[spi_pkg::REG_CLK_DIVIDER] <=
                spi_pkg::AXIL_DATA_WIDTH'(spi_pkg::SPI_DIVIDER_INIT);
            regs[spi_pkg::REG_WAIT_TIME] <=
                spi_pkg::AXIL_DATA_WIDTH'(spi_pkg::SPI_WAIT_INIT);
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_hs && spi_pkg::SPI_REG_WRITABLE[waddr]) begin
                regs[waddr] <= s_wdata_i;
            end
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            s_rdata_o <= rd_data_i[raddr];  // Captured before any pop lands
        end
    end

endmodule

`default_nettype wire

//--- design/spi_fifo.sv
// Synchronous FIFO of data words with a last flag; valid/ready handshake on both sides
`timescale 1ns/1ns
`default_nettype none

module spi_fifo #(
    parameter int DEPTH = 16
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  spi_pkg::spi_data_t s_data_i,
    input  logic               s_last_i,
    input  logic               s_valid_i,
    output logic               s_ready_o,
    output spi_pkg::spi_data_t m_data_o,
    output logic               m_last_o,
    output logic               m_valid_o,
    input  logic               m_ready_i
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [spi_pkg::SPI_DATA_WIDTH:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign s_ready_o = (count != CW'(DEPTH));
    assign m_valid_o = (count != '0);
    assign push      = s_valid_i & s_ready_o;
    assign pop       = m_valid_o & m_ready_i;

    assign {m_last_o, m_data_o} = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= {s_last_i, s_data_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(push) - CW'(pop);
        end
    end

endmodule

`default_nettype wire

//--- design/spi_master.sv
// SPI shift engine; takes TX words, shifts them out with CPOL/CPHA and hands back RX words
`timescale 1ns/1ns
`default_nettype none

module spi_master #(
    parameter int SLAVE_NUM = 2
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic [spi_pkg::SPI_SELECT_WIDTH-1:0]  select_i,
    input  logic                                  cpol_i,
    input  logic                                  cpha_i,
    input  logic [spi_pkg::SPI_DIVIDER_WIDTH-1:0] clk_divider_i,
    input  logic [spi_pkg::SPI_WAIT_WIDTH-1:0]    wait_time_i,
    input  spi_pkg::spi_data_t                    s_data_i,
    input  logic                                  s_last_i,
    input  logic                                  s_valid_i,
    output logic                                  s_ready_o,
    output spi_pkg::spi_data_t                    m_data_o,
    output logic                                  m_last_o,
    output logic                                  m_valid_o,
    input  logic                                  m_ready_i,
    output logic                                  sclk_o,
    output logic                                  mosi_o,
    input  logic                                  miso_i,
    output logic [SLAVE_NUM-1:0]                  cs_n_o
);

    localparam int DW       = spi_pkg::SPI_DATA_WIDTH;
    localparam int EDGE_NUM = 2 * DW;
    localparam int EW       = $clog2(EDGE_NUM);

    spi_pkg::spi_state_e                    state;
    logic [spi_pkg::SPI_DIVIDER_WIDTH-1:0]  div_cnt;
    logic [spi_pkg::SPI_WAIT_WIDTH-1:0]     wait_cnt;
    logic [EW-1:0]                          edge_cnt;
    spi_pkg::spi_data_t                     tx_shift;
    spi_pkg::spi_data_t                     rx_shift;
    logic                                   last_q;
    logic                                   sclk_q;
    logic [SLAVE_NUM-1:0]                   cs_n_q;
    logic [SLAVE_NUM-1:0]                   cs_sel_n;
    logic                                   sample_edge;

    always_comb begin
        for (int i = 0; i < SLAVE_NUM; i++) begin
            cs_sel_n[i] = (select_i != i);  // Out-of-range select leaves all high
        end
    end

    // Even edges lead, so CPHA picks which edge samples
    assign sample_edge = (edge_cnt[0] == cpha_i);

    assign s_ready_o = (state == spi_pkg::IDLE);
    assign m_valid_o = (state == spi_pkg::PUSH);
    assign m_data_o  = rx_shift;
    assign m_last_o  = last_q;
    assign sclk_o    = sclk_q;
    assign mosi_o    = tx_shift[DW-1];
    assign cs_n_o    = cs_n_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state    <= spi_pkg::IDLE;
            cs_n_q   <= '1;
            sclk_q   <= cpol_i;
            tx_shift <= '0;
        end else begin
            case (state)
                spi_pkg::IDLE: begin
                    sclk_q <= cpol_i;
                    if (s_valid_i) begin
                        tx_shift <= s_data_i;
                        last_q   <= s_last_i;
                        cs_n_q   <= cs_sel_n;
                        wait_cnt <= '0;
                        state    <= spi_pkg::WAIT;
                    end
                end
                spi_pkg::WAIT: begin
                    sclk_q <= cpol_i;
                    if (wait_cnt >= wait_time_i) begin
                        div_cnt  <= '0;
                        edge_cnt <= '0;
                        state    <= spi_pkg::SHIFT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                spi_pkg::SHIFT: begin
                    if (div_cnt == clk_divider_i) begin  // Half period done
                        div_cnt  <= '0;
                        sclk_q   <= ~sclk_q;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (sample_edge) begin
                            rx_shift <= {rx_shift[DW-2:0], miso_i};
                        end else if (edge_cnt != '0) begin
                            tx_shift <= {tx_shift[DW-2:0], 1'b0};
                        end
                        if (edge_cnt == EW'(EDGE_NUM - 1)) state <= spi_pkg::PUSH;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                spi_pkg::PUSH: begin
                    if (m_ready_i) begin
                        if (last_q) cs_n_q <= '1;  // Hold CS across a burst
                        state <= spi_pkg::IDLE;
                    end
                end
                default: state <= spi_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/axil_spi.sv
// Top level of the AXI-Lite SPI master; joins register file, TX/RX FIFOs and shift engine
`timescale 1ns/1ns
`default_nettype none

module axil_spi #(
    parameter int FIFO_DEPTH = 16,
    parameter int SLAVE_NUM  = 2
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [spi_pkg::AXIL_ADDR_WIDTH-1:0] s_awaddr_i,
    input  logic                                s_awvalid_i,
    output logic                                s_awready_o,
    input  logic [spi_pkg::AXIL_DATA_WIDTH-1:0] s_wdata_i,
    input  logic                                s_wvalid_i,
    output logic                                s_wready_o,
    output logic                                s_bvalid_o,
    input  logic                                s_bready_i,
    input  logic [spi_pkg::AXIL_ADDR_WIDTH-1:0] s_araddr_i,
    input  logic                                s_arvalid_i,
    output logic                                s_arready_o,
    output logic [spi_pkg::AXIL_DATA_WIDTH-1:0] s_rdata_o,
    output logic                                s_rvalid_o,
    input  logic                                s_rready_i,
    output logic                                sclk_o,
    output logic                                mosi_o,
    input  logic                                miso_i,
    output logic [SLAVE_NUM-1:0]                cs_n_o
);

    logic [spi_pkg::SPI_REG_NUM-1:0][spi_pkg::AXIL_DATA_WIDTH-1:0] wr_data;
    logic [spi_pkg::SPI_REG_NUM-1:0][spi_pkg::AXIL_DATA_WIDTH-1:0] rd_data;
    logic [spi_pkg::SPI_REG_NUM-1:0] wr_valid;
    logic [spi_pkg::SPI_REG_NUM-1:0] rd_request;
    logic                            core_rst_n;

    spi_pkg::spi_data_t tx_data, rx_data, fifo_rx_data;
    logic               tx_last, tx_valid, tx_ready;
    logic               rx_last, rx_valid, rx_ready;
    logic               fifo_tx_ready, fifo_rx_last, fifo_rx_valid;

    // Soft reset clears the data path only
    assign core_rst_n = rst_n_i & ~wr_data[spi_pkg::REG_CONTROL][spi_pkg::SPI_CTRL_RESET_POS];

    always_comb begin
        rd_data = wr_data;
        rd_data[spi_pkg::REG_PARAM] = {8'(spi_pkg::SPI_REG_NUM), 16'(FIFO_DEPTH),
                                       8'(spi_pkg::SPI_DATA_WIDTH)};
        rd_data[spi_pkg::REG_STATUS] = '0;
        rd_data[spi_pkg::REG_STATUS][spi_pkg::SPI_STATUS_RX_EMPTY_POS] = ~fifo_rx_valid;
        rd_data[spi_pkg::REG_STATUS][spi_pkg::SPI_STATUS_TX_EMPTY_POS] = ~tx_valid;
        rd_data[spi_pkg::REG_STATUS][spi_pkg::SPI_STATUS_RX_FULL_POS]  = ~rx_ready;
        rd_data[spi_pkg::REG_STATUS][spi_pkg::SPI_STATUS_TX_FULL_POS]  = ~fifo_tx_ready;
        rd_data[spi_pkg::REG_RX] = '0;  // Empty FIFO reads as zero
        if (fifo_rx_valid) begin
            rd_data[spi_pkg::REG_RX][spi_pkg::SPI_LAST_POS] = fifo_rx_last;
            rd_data[spi_pkg::REG_RX][spi_pkg::SPI_DATA_WIDTH-1:0] = fifo_rx_data;
        end
    end

    spi_reg_file u_reg_file (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .rd_data_i   (rd_data),
        .wr_data_o   (wr_data),
        .wr_valid_o  (wr_valid),
        .rd_request_o(rd_request)
    );

    spi_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_tx (
        .clk_i    (clk_i),
        .rst_n_i  (core_rst_n),
        .s_data_i (wr_data[spi_pkg::REG_TX][spi_pkg::SPI_DATA_WIDTH-1:0]),
        .s_last_i (wr_data[spi_pkg::REG_TX][spi_pkg::SPI_LAST_POS]),
        .s_valid_i(wr_valid[spi_pkg::REG_TX]),  // Dropped when full
        .s_ready_o(fifo_tx_ready),
        .m_data_o (tx_data),
        .m_last_o (tx_last),
        .m_valid_o(tx_valid),
        .m_ready_i(tx_ready)
    );

    spi_master #(.SLAVE_NUM(SLAVE_NUM)) u_master (
        .clk_i        (clk_i),
        .rst_n_i      (core_rst_n),
        .select_i     (wr_data[spi_pkg::REG_SLAVE][spi_pkg::SPI_SELECT_WIDTH-1:0]),
        .cpol_i       (wr_data[spi_pkg::REG_CONTROL][spi_pkg::SPI_CTRL_CPOL_POS]),
        .cpha_i       (wr_data[spi_pkg::REG_CONTROL][spi_pkg::SPI_CTRL_CPHA_POS]),
        .clk_divider_i(wr_data[spi_pkg::REG_CLK_DIVIDER][spi_pkg::SPI_DIVIDER_WIDTH-1:0]),
        .wait_time_i  (wr_data[spi_pkg::REG_WAIT_TIME][spi_pkg::SPI_WAIT_WIDTH-1:0]),
        .s_data_i     (tx_data),
        .s_last_i     (tx_last),
        .s_valid_i    (tx_valid),
        .s_ready_o    (tx_ready),
        .m_data_o     (rx_data),
        .m_last_o     (rx_last),
        .m_valid_o    (rx_valid),
        .m_ready_i    (rx_ready),
        .sclk_o       (sclk_o),
        .mosi_o       (mosi_o),
        .miso_i       (miso_i),
        .cs_n_o       (cs_n_o)
    );

    spi_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_rx (
        .clk_i    (clk_i),
        .rst_n_i  (core_rst_n),
        .s_data_i (rx_data),
        .s_last_i (rx_last),
        .s_valid_i(rx_valid),
        .s_ready_o(rx_ready),
        .m_data_o (fifo_rx_data),
        .m_last_o (fifo_rx_last),
        .m_valid_o(fifo_rx_valid),
        .m_ready_i(rd_request[spi_pkg::REG_RX])  // Pop on RX read
    );

endmodule

`default_nettype wire

//--- dv/spi_clk_gen.sv
// Testbench clock and reset source; 20 ns clock, reset held low for two cycles
`timescale 1ns/1ns
`default_nettype none

module spi_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;  // Released on a falling edge like every other input
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- dv/axil_spi_tb.sv
// Directed testbench for the AXI-Lite SPI master; runs with MOSI looped back to MISO
`timescale 1ns/1ns
`default_nettype none

module axil_spi_tb;

    localparam int FIFO_DEPTH    = 16;
    localparam int SLAVE_NUM     = 2;
    localparam int AXIL_TIMEOUT  = 50;
    localparam int FAST_WORDS    = 34;  // Single, 8 bursts of 4, slave select
    localparam int SLOW_WORDS    = 1;
    localparam int MARGIN_CYCLES = 10000;
    localparam int SLOW_SETTING  = 16'hFFFF;

    logic                                clk, rst_n;
    logic [spi_pkg::AXIL_ADDR_WIDTH-1:0] awaddr, araddr;
    logic [spi_pkg::AXIL_DATA_WIDTH-1:0] wdata, rdata;
    logic                                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                                arvalid, arready, rvalid, rready;
    logic                                sclk, mosi, miso;
    logic [SLAVE_NUM-1:0]                cs_n;

    logic [31:0] lcg_state;
    int          cycle_count;
    int          cs_low_cycles [SLAVE_NUM];
    int          aw_accepts;
    int          w_accepts;
    logic        idle_check_en;
    logic        cpol_expect;

    spi_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    axil_spi #(.FIFO_DEPTH(FIFO_DEPTH), .SLAVE_NUM(SLAVE_NUM)) u_dut (
        .clk_i(clk), .rst_n_i(rst_n),
        .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
        .s_wdata_i(wdata), .s_wvalid_i(wvalid), .s_wready_o(wready),
        .s_bvalid_o(bvalid), .s_bready_i(bready),
        .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
        .s_rdata_o(rdata), .s_rvalid_o(rvalid), .s_rready_i(rready),
        .sclk_o(sclk), .mosi_o(mosi), .miso_i(miso), .cs_n_o(cs_n)
    );

    assign miso = mosi;  // Loopback slave

    function automatic spi_pkg::spi_data_t next_random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Cycles per word: wait, 16 half periods of divider+1, plus state overhead
    function automatic int word_cycles(input int div, input int wt);
        return (wt + 2) + 2 * spi_pkg::SPI_DATA_WIDTH * (div + 1) + 4;
    endfunction

    function automatic logic [31:0] status_word(input logic rx_empty, input logic tx_empty,
                                                input logic rx_full, input logic tx_full);
        logic [31:0] w;
        w = '0;
        w[spi_pkg::SPI_STATUS_RX_EMPTY_POS] = rx_empty;
        w[spi_pkg::SPI_STATUS_TX_EMPTY_POS] = tx_empty;
        w[spi_pkg::SPI_STATUS_RX_FULL_POS]  = rx_full;
        w[spi_pkg::SPI_STATUS_TX_FULL_POS]  = tx_full;
        return w;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input spi_pkg::spi_data_t exp,
                              input spi_pkg::spi_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected 0x%02h, got 0x%02h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected %b, got %b", name, exp, act));
        end
    endtask

    task automatic check_word(input string name,
                              input logic [spi_pkg::AXIL_DATA_WIDTH-1:0] exp,
                              input logic [spi_pkg::AXIL_DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, act));
        end
    endtask

    // Called on a falling edge, returns on the falling edge that shows bvalid
    task automatic axil_write(input spi_pkg::spi_reg_addr_e idx, input logic [31:0] data);
        int waited;
        int aw_before;
        int w_before;
        waited    = 0;
        aw_before = aw_accepts;
        w_before  = w_accepts;
        awaddr    = {idx, 2'b00};
        wdata     = data;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        do begin
            @(negedge clk);
            waited++;
            if (waited > AXIL_TIMEOUT) abort_run("AXI-Lite write got no response");
        end while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_flag("axil_aw_accepted_once", 1'b1, aw_accepts == aw_before + 1);
        check_flag("axil_w_accepted_once", 1'b1, w_accepts == w_before + 1);
    endtask

    task automatic axil_read(input spi_pkg::spi_reg_addr_e idx, output logic [31:0] data);
        int waited;
        waited  = 0;
        araddr  = {idx, 2'b00};
        arvalid = 1'b1;
        do begin
            @(negedge clk);
            waited++;
            if (waited > AXIL_TIMEOUT) abort_run("AXI-Lite read got no response");
        end while (!rvalid);
        data    = rdata;
        arvalid = 1'b0;
    endtask

    task automatic send_word(input spi_pkg::spi_data_t data, input logic last);
        axil_write(spi_pkg::REG_TX, 32'({last, data}));
    endtask

    task automatic wait_rx_word(input int limit);
        logic [31:0] status;
        int          start;
        start = cycle_count;
        axil_read(spi_pkg::REG_STATUS, status);
        while (status[spi_pkg::SPI_STATUS_RX_EMPTY_POS]) begin
            if (cycle_count - start > limit) abort_run("No RX word arrived in time");
            axil_read(spi_pkg::REG_STATUS, status);
        end
    endtask

    task automatic check_rx(input string name, input spi_pkg::spi_data_t exp, input logic last);
        logic [31:0] w;
        axil_read(spi_pkg::REG_RX, w);
        check_data(name, exp, w[spi_pkg::SPI_DATA_WIDTH-1:0]);
        check_flag({name, "_last"}, last, w[spi_pkg::SPI_LAST_POS]);
    endtask

    task automatic read_reset_values();
        logic [31:0] w;
        check_flag("reset_sclk", 1'b0, sclk);
        check_flag("reset_cs_n", 1'b1, &cs_n);
        check_flag("reset_bvalid", 1'b0, bvalid);
        check_flag("reset_rvalid", 1'b0, rvalid);
        check_flag("reset_arready", 1'b0, arready);
        axil_read(spi_pkg::REG_PARAM, w);
        check_word("reset_param", {8'd8, 16'(FIFO_DEPTH), 8'd8}, w);
        axil_read(spi_pkg::REG_CONTROL, w);
        check_word("reset_control", 32'h0, w);
        axil_read(spi_pkg::REG_CLK_DIVIDER, w);
        check_word("reset_divider", 32'h1, w);
        axil_read(spi_pkg::REG_STATUS, w);
        check_word("reset_status", status_word(1'b1, 1'b1, 1'b0, 1'b0), w);
    endtask

    task automatic loop_back_single();
        spi_pkg::spi_data_t data;
        data = next_random_byte();
        send_word(data, 1'b1);
        wait_rx_word(2 * word_cycles(1, 0) + 100);
        check_rx("single_word", data, 1'b1);
        check_flag("single_cs0_released", 1'b1, cs_n[0]);
        check_flag("single_sclk_idle", 1'b0, sclk);
    endtask

    task automatic sweep_modes();
        spi_pkg::spi_data_t sent [4];
        logic [31:0]        ctrl;
        int                 div;
        for (int m = 0; m < 4; m++) begin
            for (int d = 0; d < 2; d++) begin
                div  = (d == 0) ? 0 : 3;
                ctrl = '0;
                ctrl[spi_pkg::SPI_CTRL_CPOL_POS] = m[0];
                ctrl[spi_pkg::SPI_CTRL_CPHA_POS] = m[1];
                axil_write(spi_pkg::REG_CONTROL, ctrl);
                axil_write(spi_pkg::REG_CLK_DIVIDER, 32'(div));
                cpol_expect   = m[0];
                idle_check_en = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    sent[i] = next_random_byte();
                    send_word(sent[i], i == 3);
                end
                for (int i = 0; i < 4; i++) begin
                    wait_rx_word(2 * word_cycles(div, 0) + 100);
                    check_rx($sformatf("mode%0d_div%0d_word%0d", m, div, i), sent[i], i == 3);
                end
                idle_check_en = 1'b0;  // CPOL may change with the next setup
            end
        end
        axil_write(spi_pkg::REG_CONTROL, 32'h0);
        axil_write(spi_pkg::REG_CLK_DIVIDER, 32'h1);
    endtask

    task automatic select_slave_one();
        spi_pkg::spi_data_t data;
        int                 low0, low1;
        axil_write(spi_pkg::REG_SLAVE, 32'h1);
        low0 = cs_low_cycles[0];
        low1 = cs_low_cycles[1];
        data = next_random_byte();
        send_word(data, 1'b1);
        wait_rx_word(2 * word_cycles(1, 0) + 100);
        check_rx("slave1_word", data, 1'b1);
        check_flag("slave0_cs_untouched", 1'b1, cs_low_cycles[0] == low0);
        check_flag("slave1_cs_asserted", 1'b1, cs_low_cycles[1] != low1);
        axil_write(spi_pkg::REG_SLAVE, 32'h0);
    endtask

    task automatic fill_tx_fifo();
        logic [31:0] status;
        int          start;
        axil_write(spi_pkg::REG_WAIT_TIME, 32'(SLOW_SETTING));
        axil_write(spi_pkg::REG_CLK_DIVIDER, 32'(SLOW_SETTING));
        start = cycle_count;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_word(next_random_byte(), 1'b0);  // One in the engine, one dropped
        end
        axil_read(spi_pkg::REG_STATUS, status);
        check_flag("full_tx_full", 1'b1, status[spi_pkg::SPI_STATUS_TX_FULL_POS]);
        check_flag("full_rx_empty", 1'b1, status[spi_pkg::SPI_STATUS_RX_EMPTY_POS]);
        wait_rx_word(2 * word_cycles(SLOW_SETTING, SLOW_SETTING));
        check_flag("full_first_word_time", 1'b1,
                   (cycle_count - start) >= word_cycles(SLOW_SETTING, SLOW_SETTING) - 6);
    endtask

    task automatic apply_soft_reset();
        logic [31:0] w;
        axil_read(spi_pkg::REG_STATUS, w);
        check_flag("soft_reset_rx_pending", 1'b0, w[spi_pkg::SPI_STATUS_RX_EMPTY_POS]);
        axil_write(spi_pkg::REG_CONTROL, 32'h1 << spi_pkg::SPI_CTRL_RESET_POS);
        axil_write(spi_pkg::REG_CONTROL, 32'h0);
        axil_read(spi_pkg::REG_STATUS, w);
        check_word("soft_reset_status", status_word(1'b1, 1'b1, 1'b0, 1'b0), w);
        axil_read(spi_pkg::REG_RX, w);
        check_word("soft_reset_rx", 32'h0, w);
        check_flag("soft_reset_cs_n", 1'b1, &cs_n);
    endtask

    // Registered DUT outputs read at the rising edge hold their pre-edge values
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst_n) begin
            for (int i = 0; i < SLAVE_NUM; i++) begin
                if (!cs_n[i]) cs_low_cycles[i] <= cs_low_cycles[i] + 1;
            end
            if (awvalid && awready) aw_accepts <= aw_accepts + 1;
            if (wvalid && wready) w_accepts <= w_accepts + 1;
            if (idle_check_en && (&cs_n)) check_flag("sclk_idle_at_cpol", cpol_expect, sclk);
        end
    end

    initial begin
        repeat (FAST_WORDS * word_cycles(3, 0) + SLOW_WORDS
                * word_cycles(SLOW_SETTING, SLOW_SETTING) + MARGIN_CYCLES) @(posedge clk);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wvalid        = 1'b0;
        bready        = 1'b1;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b1;
        lcg_state     = 32'h7a4a86af;
        idle_check_en = 1'b0;
        cpol_expect   = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        read_reset_values();
        loop_back_single();
        sweep_modes();
        select_slave_one();
        fill_tx_fifo();
        apply_soft_reset();  // Relies on the RX word left by the full test
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/spi_pkg.sv
design/spi_reg_file.sv
design/spi_fifo.sv
design/spi_master.sv
design/axil_spi.sv
dv/spi_clk_gen.sv
dv/axil_spi_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= axil_spi_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
BIN       ?= V$(TOP)
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(BIN)

run: compile
	@out="$$(./$(BUILD_DIR)/$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
